// File: logic/zet_micro_pkg.sv
package zet_micro_pkg;

  // ##############################
  // widths
  localparam int unsigned MICRO_ADDR_WIDTH = 5;   // 32 rom words.
  localparam int unsigned MICRO_DATA_WIDTH = 50;  // raw rom word.
  localparam int unsigned IR_SIZE          = 36;  // expanded instruction word.

  typedef logic [MICRO_ADDR_WIDTH-1:0] micro_addr_t;
  typedef logic [MICRO_DATA_WIDTH-1:0] micro_word_t;
  typedef logic [IR_SIZE-1:0]          ir_t;
  typedef logic [15:0]                 word_t;      // offsets and immediates.
  typedef logic [3:0]                  reg_sel_t;   // register file address.
  typedef logic [1:0]                  seg_sel_t;   // segment register.
  typedef logic [2:0]                  alu_func_t;  // alu function code.

  // ##############################
  // rom word layout, lsb of each field
  // the low 36 bits keep the same order as the expanded ir.
  localparam int unsigned MW_S_LO       = 0;   // segment constant.
  localparam int unsigned MW_A_LO       = 2;   // register a constant.
  localparam int unsigned MW_B_LO       = 6;
  localparam int unsigned MW_C_LO       = 10;
  localparam int unsigned MW_D_LO       = 14;
  localparam int unsigned MW_WR_FLAG    = 18;  // flag write.
  localparam int unsigned MW_WR_MEM     = 19;  // memory write.
  localparam int unsigned MW_WR_ROM     = 20;  // register write before cmp gating.
  localparam int unsigned MW_IR0_LO     = 21;
  localparam int unsigned MW_T_LO       = 23;  // unit select.
  localparam int unsigned MW_F_LO       = 26;  // function within unit.
  localparam int unsigned MW_IR1_LO     = 29;
  localparam int unsigned MW_VAR_S      = 36;  // segment from instruction.
  localparam int unsigned MW_VAR_A_LO   = 37;
  localparam int unsigned MW_VAR_B_LO   = 39;
  localparam int unsigned MW_VAR_C_LO   = 41;
  localparam int unsigned MW_VAR_D_LO   = 43;
  localparam int unsigned MW_VAR_OFF    = 45;  // pass offset through.
  localparam int unsigned MW_VAR_IMM_LO = 46;  // immediate source select.
  localparam int unsigned MW_END_SEQ    = 49;  // last word of a sequence.

  // special unit and function codes.
  localparam logic [2:0] T_ALU    = 3'd5;
  localparam logic [2:0] T_FLAGOP = 3'd6;
  localparam alu_func_t  F_CMP    = 3'd7;

  // ##############################
  // stream payloads
  typedef struct packed {
    micro_addr_t entry;  // first rom word of the sequence.
    word_t       off;
    word_t       imm;
    reg_sel_t    src;
    reg_sel_t    dst;
    reg_sel_t    base;
    reg_sel_t    index;
    seg_sel_t    seg;
    alu_func_t   fdec;   // decoded alu function.
  } dec_instr_t;

  typedef struct packed {
    ir_t   ir;
    word_t off;
    word_t imm;
    logic  last;  // end of sequence.
  } uop_t;

endpackage

// File: logic/zet_micro_rom.sv
module zet_micro_rom (
  input  zet_micro_pkg::micro_addr_t addr_i,
  output zet_micro_pkg::micro_word_t word_o
);
  import zet_micro_pkg::*;

  // selector and sequencing fields.
  function automatic micro_word_t var_fields(input logic end_seq, input logic [2:0] v_imm,
                                             input logic v_off, input logic [1:0] v_d,
                                             input logic [1:0] v_c, input logic [1:0] v_b,
                                             input logic [1:0] v_a, input logic v_s);
    micro_word_t w;
    w = '0;
    w[MW_END_SEQ]             = end_seq;
    w[MW_VAR_IMM_LO +: 3]     = v_imm;
    w[MW_VAR_OFF]             = v_off;
    w[MW_VAR_D_LO +: 2]       = v_d;
    w[MW_VAR_C_LO +: 2]       = v_c;
    w[MW_VAR_B_LO +: 2]       = v_b;
    w[MW_VAR_A_LO +: 2]       = v_a;
    w[MW_VAR_S]               = v_s;
    return w;
  endfunction

  // opcode and write enables.
  function automatic micro_word_t op_fields(input logic [6:0] ir1, input logic [2:0] f,
                                            input logic [2:0] t, input logic [1:0] ir0,
                                            input logic wr_rom, input logic wr_mem,
                                            input logic wr_flag);
    micro_word_t w;
    w = '0;
    w[MW_IR1_LO +: 7] = ir1;
    w[MW_F_LO +: 3]   = f;
    w[MW_T_LO +: 3]   = t;
    w[MW_IR0_LO +: 2] = ir0;
    w[MW_WR_ROM]      = wr_rom;
    w[MW_WR_MEM]      = wr_mem;
    w[MW_WR_FLAG]     = wr_flag;
    return w;
  endfunction

  // constant register and segment addresses.
  function automatic micro_word_t reg_fields(input reg_sel_t d, input reg_sel_t c,
                                             input reg_sel_t b, input reg_sel_t a,
                                             input seg_sel_t s);
    micro_word_t w;
    w = '0;
    w[MW_D_LO +: 4] = d;
    w[MW_C_LO +: 4] = c;
    w[MW_B_LO +: 4] = b;
    w[MW_A_LO +: 4] = a;
    w[MW_S_LO +: 2] = s;
    return w;
  endfunction

  always_comb begin
    unique case (addr_i)
      // register move.
      5'd0:  word_o = var_fields(1'b1, 3'd0, 1'b0, 2'd0, 2'd1, 2'd0, 2'd3, 1'b0)
                    | op_fields(7'h01, 3'd0, 3'd1, 2'd0, 1'b1, 1'b0, 1'b0);
      // alu op then flag update, function from fdec.
      5'd2:  word_o = var_fields(1'b0, 3'd4, 1'b0, 2'd1, 2'd1, 2'd2, 2'd2, 1'b0)
                    | op_fields(7'h02, 3'd0, T_ALU, 2'd0, 1'b1, 1'b0, 1'b0);
      5'd3:  word_o = var_fields(1'b1, 3'd0, 1'b0, 2'd0, 2'd0, 2'd0, 2'd0, 1'b0)
                    | op_fields(7'h02, 3'd0, T_FLAGOP, 2'd0, 1'b0, 1'b0, 1'b1);
      // load via base + index + disp.
      5'd5:  word_o = var_fields(1'b0, 3'd3, 1'b1, 2'd0, 2'd0, 2'd1, 2'd1, 1'b0)
                    | op_fields(7'h03, 3'd1, 3'd2, 2'd0, 1'b0, 1'b0, 1'b0)
                    | reg_fields(4'd0, 4'd0, 4'd0, 4'd0, 2'd3);
      5'd6:  word_o = var_fields(1'b0, 3'd0, 1'b1, 2'd0, 2'd0, 2'd0, 2'd0, 1'b0)
                    | op_fields(7'h04, 3'd0, 3'd3, 2'd1, 1'b0, 1'b0, 1'b0)
                    | reg_fields(4'd0, 4'd0, 4'd0, 4'd0, 2'd3);
      5'd7:  word_o = var_fields(1'b1, 3'd0, 1'b0, 2'd1, 2'd1, 2'd0, 2'd0, 1'b0)
                    | op_fields(7'h05, 3'd0, 3'd1, 2'd0, 1'b1, 1'b0, 1'b0);
      // increment by constant one.
      5'd9:  word_o = var_fields(1'b1, 3'd7, 1'b0, 2'd1, 2'd1, 2'd0, 2'd2, 1'b0)
                    | op_fields(7'h06, 3'd0, 3'd4, 2'd0, 1'b1, 1'b0, 1'b0);
      // push. sp is register 4 and ss is segment 2.
      5'd12: word_o = var_fields(1'b0, 3'd1, 1'b0, 2'd0, 2'd0, 2'd0, 2'd0, 1'b0)
                    | op_fields(7'h07, 3'd1, 3'd4, 2'd0, 1'b1, 1'b0, 1'b0)
                    | reg_fields(4'd4, 4'd4, 4'd0, 4'd4, 2'd2);
      5'd13: word_o = var_fields(1'b1, 3'd0, 1'b0, 2'd0, 2'd0, 2'd2, 2'd0, 1'b0)
                    | op_fields(7'h08, 3'd0, 3'd3, 2'd2, 1'b0, 1'b1, 1'b0)
                    | reg_fields(4'd0, 4'd0, 4'd0, 4'd4, 2'd2);
      // string step over si and di.
      5'd16: word_o = var_fields(1'b0, 3'd5, 1'b0, 2'd0, 2'd0, 2'd0, 2'd0, 1'b1)
                    | op_fields(7'h09, 3'd0, 3'd2, 2'd0, 1'b0, 1'b0, 1'b0)
                    | reg_fields(4'd0, 4'd0, 4'd0, 4'd6, 2'd0);
      5'd17: word_o = var_fields(1'b0, 3'd6, 1'b0, 2'd2, 2'd2, 2'd3, 2'd3, 1'b1)
                    | op_fields(7'h0a, 3'd2, 3'd1, 2'd0, 1'b1, 1'b0, 1'b0);
      5'd18: word_o = var_fields(1'b0, 3'd0, 1'b0, 2'd0, 2'd0, 2'd0, 2'd0, 1'b0)
                    | op_fields(7'h0b, 3'd0, 3'd3, 2'd1, 1'b0, 1'b1, 1'b0)
                    | reg_fields(4'd0, 4'd0, 4'd0, 4'd7, 2'd0);
      5'd19: word_o = var_fields(1'b1, 3'd2, 1'b0, 2'd0, 2'd0, 2'd0, 2'd0, 1'b0)
                    | op_fields(7'h0c, 3'd1, 3'd4, 2'd0, 1'b1, 1'b0, 1'b0)
                    | reg_fields(4'd1, 4'd0, 4'd0, 4'd1, 2'd0);
      // empty word that just ends the sequence.
      default: word_o = var_fields(1'b1, 3'd0, 1'b0, 2'd0, 2'd0, 2'd0, 2'd0, 1'b0);
    endcase
  end

endmodule

// File: logic/zet_micro_data.sv
module zet_micro_data (
  input  zet_micro_pkg::micro_word_t word_i,
  input  zet_micro_pkg::dec_instr_t  dec_i,
  output logic                       end_seq_o,
  output zet_micro_pkg::ir_t         ir_o,
  output zet_micro_pkg::word_t       off_o,
  output zet_micro_pkg::word_t       imm_o
);
  import zet_micro_pkg::*;

  // raw rom fields.
  seg_sel_t   rom_s;
  reg_sel_t   rom_a, rom_b, rom_c, rom_d;
  logic       wr_flag, wr_mem, wr_rom;
  logic [1:0] ir0;
  logic [2:0] t;
  alu_func_t  f_rom;
  logic [6:0] ir1;
  logic       var_s, var_off;
  logic [1:0] var_a, var_b, var_c, var_d;
  logic [2:0] var_imm;

  // resolved fields.
  seg_sel_t   addr_s;
  reg_sel_t   addr_a, addr_b, addr_c, addr_d;
  alu_func_t  f;
  logic       wr_d;

  // ##############################
  // field split
  assign rom_s     = word_i[MW_S_LO +: 2];
  assign rom_a     = word_i[MW_A_LO +: 4];
  assign rom_b     = word_i[MW_B_LO +: 4];
  assign rom_c     = word_i[MW_C_LO +: 4];
  assign rom_d     = word_i[MW_D_LO +: 4];
  assign wr_flag   = word_i[MW_WR_FLAG];
  assign wr_mem    = word_i[MW_WR_MEM];
  assign wr_rom    = word_i[MW_WR_ROM];
  assign ir0       = word_i[MW_IR0_LO +: 2];
  assign t         = word_i[MW_T_LO +: 3];
  assign f_rom     = word_i[MW_F_LO +: 3];
  assign ir1       = word_i[MW_IR1_LO +: 7];
  assign var_s     = word_i[MW_VAR_S];
  assign var_a     = word_i[MW_VAR_A_LO +: 2];
  assign var_b     = word_i[MW_VAR_B_LO +: 2];
  assign var_c     = word_i[MW_VAR_C_LO +: 2];
  assign var_d     = word_i[MW_VAR_D_LO +: 2];
  assign var_off   = word_i[MW_VAR_OFF];
  assign var_imm   = word_i[MW_VAR_IMM_LO +: 3];
  assign end_seq_o = word_i[MW_END_SEQ];

  // ##############################
  // operand selection
  always_comb begin
    unique case (var_imm)
      3'd0:    imm_o = 16'h0000;
      3'd1:    imm_o = 16'h0002;   // word step.
      3'd2:    imm_o = 16'h0004;   // dword step.
      3'd3:    imm_o = dec_i.off;  // displacement as operand.
      3'd4:    imm_o = dec_i.imm;
      3'd5:    imm_o = 16'hffff;   // minus one.
      3'd6:    imm_o = 16'h0003;
      default: imm_o = 16'h0001;
    endcase
  end

  assign off_o = var_off ? dec_i.off : 16'h0000;  // zero unless addressing uses it.

  always_comb begin
    unique case (var_a)
      2'd0:    addr_a = rom_a;
      2'd1:    addr_a = dec_i.base;
      2'd2:    addr_a = dec_i.dst;
      default: addr_a = dec_i.src;
    endcase
    addr_b = (var_b == 2'd0) ? rom_b : (var_b == 2'd1) ? dec_i.index : dec_i.src;
    addr_c = (var_c == 2'd0) ? rom_c : (var_c == 2'd1) ? dec_i.dst : dec_i.src;
    addr_d = (var_d == 2'd0) ? rom_d : (var_d == 2'd1) ? dec_i.dst : dec_i.src;
  end

  assign addr_s = var_s ? dec_i.seg : rom_s;

  // flagged alu words take the decoded function.
  assign f    = ((t == T_FLAGOP && wr_flag) || (t == T_ALU && wr_rom)) ? dec_i.fdec : f_rom;
  assign wr_d = (t == T_ALU && f == F_CMP) ? 1'b0 : wr_rom;  // compare only sets flags.

  assign ir_o = {ir1, f, t, ir0, wr_d, wr_mem, wr_flag,
                 addr_d, addr_c, addr_b, addr_a, addr_s};

  // checked on the packed word so a field misorder shows up too.
  always_comb begin
    a_cmp_no_wb : assert final (!(ir_o[MW_T_LO +: 3] === T_ALU &&
                                  ir_o[MW_F_LO +: 3] === F_CMP &&
                                  ir_o[MW_WR_ROM] === 1'b1))
      else $error("alu compare carries a register write");
  end

endmodule

// File: logic/zet_micro_seq.sv
module zet_micro_seq (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       dec_valid_i,
  input  zet_micro_pkg::dec_instr_t  dec_i,
  output logic                       dec_ready_o,
  input  logic                       end_seq_i,
  input  logic                       uop_ready_i,
  output logic                       uop_valid_o,
  output zet_micro_pkg::micro_addr_t addr_o,
  output zet_micro_pkg::dec_instr_t  held_o
);
  import zet_micro_pkg::*;

  typedef enum logic {
    IDLE,  // waiting for a decoded instruction.
    RUN    // streaming micro-ops.
  } state_e;

  state_e      state_q;
  micro_addr_t addr_q;
  dec_instr_t  held_q;
  logic        dec_fire;
  logic        uop_fire;

  // ##############################
  // handshakes
  assign dec_ready_o = (state_q == IDLE);
  assign uop_valid_o = (state_q == RUN);
  assign dec_fire    = dec_valid_i & dec_ready_o;
  assign uop_fire    = uop_valid_o & uop_ready_i;

  // ##############################
  // state and micro address
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
      addr_q  <= '0;
    end else begin
      unique case (state_q)
        IDLE: begin
          if (dec_fire) begin
            state_q <= RUN;
            addr_q  <= dec_i.entry;  // first word shows next cycle.
          end
        end
        RUN: begin
          if (uop_fire) begin
            addr_q <= addr_q + micro_addr_t'(1);  // next word of the sequence.
            if (end_seq_i) begin
              state_q <= IDLE;
            end
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // instruction fields stay put for the whole sequence.
  always_ff @(posedge clk_i) begin
    if (dec_fire) begin
      held_q <= dec_i;
    end
  end

  assign addr_o = addr_q;
  assign held_o = held_q;

  // ##############################
  // checks
  // input and output never both open.
  a_one_side : assert property (@(posedge clk_i) disable iff (reset_i)
    !(dec_ready_o && uop_valid_o))
    else $error("decoder and micro-op handshakes open together");

  // a stalled micro-op keeps its rom word and fields.
  a_stall_hold : assert property (@(posedge clk_i) disable iff (reset_i)
    (uop_valid_o && !uop_ready_i) |=> (uop_valid_o && $stable(addr_o) && $stable(held_o)))
    else $error("micro address moved under back-pressure");

endmodule

// File: logic/zet_micro_top.sv
module zet_micro_top (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      dec_valid_i,
  output logic                      dec_ready_o,
  input  zet_micro_pkg::dec_instr_t dec_i,
  output logic                      uop_valid_o,
  input  logic                      uop_ready_i,
  output zet_micro_pkg::uop_t       uop_o
);
  import zet_micro_pkg::*;

  micro_addr_t addr;     // current rom word.
  dec_instr_t  held;     // instruction being expanded.
  micro_word_t word;
  logic        end_seq;
  ir_t         ir;
  word_t       off;
  word_t       imm;

  zet_micro_seq u_seq (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .dec_valid_i (dec_valid_i),
    .dec_i       (dec_i),
    .dec_ready_o (dec_ready_o),
    .end_seq_i   (end_seq),
    .uop_ready_i (uop_ready_i),
    .uop_valid_o (uop_valid_o),
    .addr_o      (addr),
    .held_o      (held)
  );

  zet_micro_rom u_rom (
    .addr_i (addr),
    .word_o (word)
  );

  zet_micro_data u_data (
    .word_i    (word),
    .dec_i     (held),
    .end_seq_o (end_seq),
    .ir_o      (ir),
    .off_o     (off),
    .imm_o     (imm)
  );

  // end of sequence travels with the op as last.
  assign uop_o = '{ir: ir, off: off, imm: imm, last: end_seq};

endmodule

// File: testbench/zet_micro_tb.sv
module zet_micro_tb;
  import zet_micro_pkg::*;

  // one rom word as separate fields, same order as the table rows below.
  typedef struct packed {
    logic       endq;            // end of sequence.
    logic [2:0] vimm;
    logic       voff;
    logic [1:0] vd, vc, vb, va;
    logic       vs;
    logic [6:0] ir1;
    logic [2:0] f, t;
    logic [1:0] ir0;
    logic       wrr, wrm, wrf;  // register, memory and flag write.
    reg_sel_t   d, c, b, a;
    seg_sel_t   s;
  } rom_rec_t;

  localparam int WAIT_LIMIT = 100;  // cycles allowed per wait.

  logic       clk_i;
  logic       reset_i;
  logic       dec_valid_i;
  logic       dec_ready_o;
  dec_instr_t dec_i;
  logic       uop_valid_o;
  logic       uop_ready_i;
  uop_t       uop_o;

  integer seed;
  uop_t   exp_q[$];  // expected micro-ops of the instruction in flight.
  micro_addr_t directed [8] = '{5'd0, 5'd2, 5'd5, 5'd9, 5'd12, 5'd16, 5'd31, 5'd2};

  zet_micro_top DUT (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .dec_valid_i (dec_valid_i),
    .dec_ready_o (dec_ready_o),
    .dec_i       (dec_i),
    .uop_valid_o (uop_valid_o),
    .uop_ready_i (uop_ready_i),
    .uop_o       (uop_o)
  );

  always #5 clk_i = ~clk_i;

  // ##############################
  // failure reporting and compares
  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_ir(input ir_t got, input ir_t exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("ERROR %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("ERROR %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_last(input logic got, input logic exp);
    if (got !== exp) begin
      stop_run($sformatf("ERROR %0t: last is %b, expected %b", $time, got, exp));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("ERROR %0t: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  // ##############################
  // reference model
  function automatic rom_rec_t rom_model(input micro_addr_t addr);
    rom_rec_t m;
    case (addr)  //      end imm off d c b a s   ir1  f t ir0 wr  d c b a s
      5'd0:    m = '{1, 0, 0, 0, 1, 0, 3, 0, 'h01, 0, 1, 0, 1, 0, 0, 0, 0, 0, 0, 0};
      5'd2:    m = '{0, 4, 0, 1, 1, 2, 2, 0, 'h02, 0, 5, 0, 1, 0, 0, 0, 0, 0, 0, 0};
      5'd3:    m = '{1, 0, 0, 0, 0, 0, 0, 0, 'h02, 0, 6, 0, 0, 0, 1, 0, 0, 0, 0, 0};
      5'd5:    m = '{0, 3, 1, 0, 0, 1, 1, 0, 'h03, 1, 2, 0, 0, 0, 0, 0, 0, 0, 0, 3};
      5'd6:    m = '{0, 0, 1, 0, 0, 0, 0, 0, 'h04, 0, 3, 1, 0, 0, 0, 0, 0, 0, 0, 3};
      5'd7:    m = '{1, 0, 0, 1, 1, 0, 0, 0, 'h05, 0, 1, 0, 1, 0, 0, 0, 0, 0, 0, 0};
      5'd9:    m = '{1, 7, 0, 1, 1, 0, 2, 0, 'h06, 0, 4, 0, 1, 0, 0, 0, 0, 0, 0, 0};
      5'd12:   m = '{0, 1, 0, 0, 0, 0, 0, 0, 'h07, 1, 4, 0, 1, 0, 0, 4, 4, 0, 4, 2};
      5'd13:   m = '{1, 0, 0, 0, 0, 2, 0, 0, 'h08, 0, 3, 2, 0, 1, 0, 0, 0, 0, 4, 2};
      5'd16:   m = '{0, 5, 0, 0, 0, 0, 0, 1, 'h09, 0, 2, 0, 0, 0, 0, 0, 0, 0, 6, 0};
      5'd17:   m = '{0, 6, 0, 2, 2, 3, 3, 1, 'h0a, 2, 1, 0, 1, 0, 0, 0, 0, 0, 0, 0};
      5'd18:   m = '{0, 0, 0, 0, 0, 0, 0, 0, 'h0b, 0, 3, 1, 0, 1, 0, 0, 0, 0, 7, 0};
      5'd19:   m = '{1, 2, 0, 0, 0, 0, 0, 0, 'h0c, 1, 4, 0, 1, 0, 0, 1, 0, 0, 1, 0};
      default: m = '{1, 0, 0, 0, 0, 0, 0, 0, 'h00, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0};
    endcase
    return m;
  endfunction

  function automatic uop_t expand(input rom_rec_t m, input dec_instr_t h);
    uop_t      u;
    reg_sel_t  ra, rb, rc, rd;
    seg_sel_t  rs;
    alu_func_t f;
    logic      wr_d;
    case (m.vimm)
      3'd0:    u.imm = 16'h0000;
      3'd1:    u.imm = 16'h0002;
      3'd2:    u.imm = 16'h0004;
      3'd3:    u.imm = h.off;
      3'd4:    u.imm = h.imm;
      3'd5:    u.imm = 16'hffff;
      3'd6:    u.imm = 16'h0003;
      default: u.imm = 16'h0001;
    endcase
    u.off = m.voff ? h.off : 16'h0000;
    ra = (m.va == 0) ? m.a : (m.va == 1) ? h.base : (m.va == 2) ? h.dst : h.src;
    rb = (m.vb == 0) ? m.b : (m.vb == 1) ? h.index : h.src;
    rc = (m.vc == 0) ? m.c : (m.vc == 1) ? h.dst : h.src;
    rd = (m.vd == 0) ? m.d : (m.vd == 1) ? h.dst : h.src;
    rs = m.vs ? h.seg : m.s;
    // flag op with flag write, or alu op with register write, uses fdec.
    f    = ((m.t == 3'd6 && m.wrf) || (m.t == 3'd5 && m.wrr)) ? h.fdec : m.f;
    wr_d = (m.t == 3'd5 && f == 3'd7) ? 1'b0 : m.wrr;  // cmp writes flags only.
    u.ir = {m.ir1, f, m.t, m.ir0, wr_d, m.wrm, m.wrf, rd, rc, rb, ra, rs};
    u.last = m.endq;
    return u;
  endfunction

  task automatic build_expected(input dec_instr_t d);
    micro_addr_t addr;
    rom_rec_t    m;
    int          n;
    addr = d.entry;
    n = 0;
    do begin
      m = rom_model(addr);
      exp_q.push_back(expand(m, d));
      addr = addr + 5'd1;  // wraps like the micro address.
      n++;
    end while (!m.endq && n < 32);
  endtask

  // ##############################
  // stimulus
  task automatic wait_dec_ready();
    int n;
    n = 0;
    while (dec_ready_o !== 1'b1) begin
      @(posedge clk_i);
      #1;
      n++;
      if (n > WAIT_LIMIT) begin
        stop_run("timeout: dec_ready_o never went high");
      end
    end
  endtask

  task automatic run_instr(input dec_instr_t d);
    uop_t got;
    uop_t stall_v;
    logic stalled;
    int   n;
    build_expected(d);
    wait_dec_ready();
    check_flag(uop_valid_o, 1'b0, "uop_valid_o while idle");
    dec_valid_i = 1'b1;
    dec_i       = d;
    @(posedge clk_i);  // ready was high, so this edge takes it.
    #1;
    dec_valid_i = 1'b0;
    stalled = 1'b0;
    n = 0;
    while (exp_q.size() > 0) begin
      uop_ready_i = ({$random(seed)} % 3) != 0;  // low about a third of the time.
      got = uop_o;  // settled since the last edge.
      check_flag(dec_ready_o, 1'b0, "dec_ready_o during sequence");
      check_flag(uop_valid_o, 1'b1, "uop_valid_o during sequence");
      if (stalled) begin  // held op must not move.
        check_ir(got.ir, stall_v.ir, "stalled ir");
        check_word(got.off, stall_v.off, "stalled off");
        check_word(got.imm, stall_v.imm, "stalled imm");
        check_last(got.last, stall_v.last);
      end
      if (uop_ready_i) begin
        check_ir(got.ir, exp_q[0].ir, "ir");
        check_word(got.off, exp_q[0].off, "off");
        check_word(got.imm, exp_q[0].imm, "imm");
        check_last(got.last, exp_q[0].last);
        exp_q.delete(0);
        stalled = 1'b0;
      end else begin
        stall_v = got;
        stalled = 1'b1;
      end
      n++;
      if (n > WAIT_LIMIT) begin
        stop_run("timeout: micro-op stream never finished the sequence");
      end
      @(posedge clk_i);  // op transfers here when ready is high.
      #1;
    end
    // one cycle after the last op, back to idle.
    check_flag(dec_ready_o, 1'b1, "dec_ready_o after last op");
    check_flag(uop_valid_o, 1'b0, "uop_valid_o after last op");
  endtask

  initial begin
    dec_instr_t  d;
    logic [63:0] r;
    seed        = 32'h940c82b1;
    clk_i       = 1'b0;
    reset_i     = 1'b1;
    dec_valid_i = 1'b0;
    dec_i       = '0;
    uop_ready_i = 1'b0;
    repeat (8) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    check_flag(uop_valid_o, 1'b0, "uop_valid_o after reset");
    check_flag(dec_ready_o, 1'b1, "dec_ready_o after reset");
    // every listed entry, one unlisted, then an alu compare.
    for (int i = 0; i < 8; i++) begin
      r = {$random(seed), $random(seed)};
      d = r[$bits(dec_instr_t)-1:0];
      d.entry = directed[i];
      if (i == 7) begin
        d.fdec = F_CMP;
      end
      run_instr(d);
    end
    for (int i = 0; i < 300; i++) begin
      r = {$random(seed), $random(seed)};
      d = r[$bits(dec_instr_t)-1:0];
      run_instr(d);
    end
    $display("Verification passed");
    $finish;
  end

endmodule

// File: project.f
logic/zet_micro_pkg.sv
logic/zet_micro_rom.sv
logic/zet_micro_data.sv
logic/zet_micro_seq.sv
logic/zet_micro_top.sv
testbench/zet_micro_tb.sv
